/* Bender.yml */
package:
  name: dispatch_issue

sources:
  - hdl/ooo_pkg.sv
  - hdl/reg_scoreboard.sv
  - hdl/rs_station.sv
  - hdl/alu_unit.sv
  - hdl/dispatch_issue.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_dispatch_issue.sv

/* bench/tb_tasks.svh */
`default_nettype none

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		// Fold the high bits down, the low LCG bits have short periods
		return lcg_state ^ (lcg_state >> 16);
	endfunction

	function automatic ooo_pkg::alu_op_e op_pick(input int n);
		case (n % 5)
			0:       return ooo_pkg::ALU_AND;
			1:       return ooo_pkg::ALU_ADD;
			2:       return ooo_pkg::ALU_SUB;
			3:       return ooo_pkg::ALU_XOR;
			default: return ooo_pkg::ALU_SRA;
		endcase
	endfunction

	function automatic logic [31:0] alu_ref(input ooo_pkg::alu_op_e op, input logic [31:0] a,
		input logic [31:0] b);
		logic [63:0] wide;
		// Sign-extend to 64 bits so a logical shift acts as an arithmetic one
		wide = {{32{a[31]}}, a} >> b[4:0];
		case (op)
			ooo_pkg::ALU_AND: return a & b;
			ooo_pkg::ALU_ADD: return a + b;
			ooo_pkg::ALU_SUB: return a - b;
			ooo_pkg::ALU_XOR: return a ^ b;
			default:          return wide[31:0];
		endcase
	endfunction

	// Nonzero dest with no result in flight
	function automatic logic [ooo_pkg::PREG_W-1:0] pick_free_dest();
		logic [ooo_pkg::PREG_W-1:0] d;
		d = 6'(next_rand() % 63) + 6'd1;
		for (int i = 0; i < 63 && preg_busy[d]; i++) begin
			d = (d == 6'd63) ? 6'd1 : d + 6'd1;
		end
		return d;
	endfunction

	task automatic report_timeout(input string why);
		$display("Timeout, %s", why);
		err_cnt++;
		aborted = 1'b1;
	endtask

	task automatic finish_test(input string name, input int err_start);
		test_cnt++;
		$display("test %s finished with %0d errors", name, err_cnt - err_start);
	endtask

	task automatic check_completion(input string name, input ooo_pkg::complete_s c);
		chk_cnt++;
		assert (rob_busy[c.rob_idx]) else begin
			$display("%s reported ROB index %0d with nothing in flight", name, c.rob_idx);
			err_cnt++;
		end
		if (rob_busy[c.rob_idx]) begin
			chk_cnt++;
			assert (c.value == rob_val[c.rob_idx]) else begin
				$display("ERROR %s.value exp %h got %h", name, rob_val[c.rob_idx], c.value);
				err_cnt++;
			end
			assert (c.dest == rob_dest[c.rob_idx]) else begin
				$display("ERROR %s.dest exp %h got %h", name, rob_dest[c.rob_idx], c.dest);
				err_cnt++;
			end
			rob_busy[c.rob_idx]            = 1'b0;
			preg_busy[rob_dest[c.rob_idx]] = 1'b0;
			pending--;
			done_cnt++;
		end
		regfile[c.dest] = c.value;
	endtask

	// Sources come from the observed register file, so in-flight tags carry stale values
	task automatic send_instr(input ooo_pkg::alu_op_e op, input logic [ooo_pkg::PREG_W-1:0] src1,
		input logic [ooo_pkg::PREG_W-1:0] src2, input logic use_imm, input logic [31:0] imm,
		output logic [ooo_pkg::PREG_W-1:0] dest);
		ooo_pkg::dispatch_s d;
		int waited;
		dest   = '0;
		waited = 0;
		if (aborted) return;
		@(posedge clk_i);
		while (credits == 0 || rob_busy[rob_next]) begin
			dispatch_valid_i <= 1'b0;
			waited++;
			if (waited > 200) begin
				report_timeout("no dispatch credit or free ROB index within 200 cycles");
				return;
			end
			@(posedge clk_i);
		end
		dest       = pick_free_dest();
		d.dest     = dest;
		d.src1     = src1;
		d.src1_val = regfile[src1];
		d.src2     = src2;
		d.src2_val = regfile[src2];
		d.imm      = imm;
		d.use_imm  = use_imm;
		d.alu_op   = op;
		d.rob_idx  = rob_next;
		rob_val[rob_next]  = alu_ref(op, exp_reg[src1], use_imm ? imm : exp_reg[src2]);
		rob_dest[rob_next] = dest;
		rob_busy[rob_next] = 1'b1;
		exp_reg[dest]      = rob_val[rob_next];
		preg_busy[dest]    = 1'b1;
		credits--;
		pending++;
		rob_next++;
		dispatch_valid_i <= 1'b1;
		dispatch_i       <= d;
	endtask

	task automatic end_dispatch();
		@(posedge clk_i);
		dispatch_valid_i <= 1'b0;
	endtask

	task automatic wait_drain(input int limit);
		int waited;
		waited = 0;
		while (pending != 0 && !aborted) begin
			@(posedge clk_i);
			waited++;
			if (waited > limit) begin
				report_timeout("completions still missing after the drain limit");
			end
		end
	endtask

	task automatic run_reset_test();
		int err_start;
		err_start = err_cnt;
		repeat (6) begin
			@(negedge clk_i);
			chk_cnt++;
			assert (credit_cnt_o == 2'd0 && !complete0_valid_o && !complete1_valid_o) else begin
				$display("ERROR credit_cnt_o/complete0_valid_o/complete1_valid_o exp 0 got %h/%h/%h",
					credit_cnt_o, complete0_valid_o, complete1_valid_o);
				err_cnt++;
			end
		end
		finish_test("reset", err_start);
	endtask

	task automatic run_op_test();
		logic [ooo_pkg::PREG_W-1:0] dest;
		int err_start;
		err_start = err_cnt;
		for (int i = 0; i < 5; i++) begin
			for (int k = 0; k < 2; k++) begin
				send_instr(op_pick(i), 6'(next_rand() % 64), 6'(next_rand() % 64), k == 1,
					next_rand(), dest);
				end_dispatch();
				wait_drain(20);
			end
		end
		finish_test("ops", err_start);
	endtask

	task automatic run_chain_test();
		logic [ooo_pkg::PREG_W-1:0] d0;
		logic [ooo_pkg::PREG_W-1:0] d1;
		logic [ooo_pkg::PREG_W-1:0] d2;
		logic [ooo_pkg::PREG_W-1:0] d3;
		int err_start;
		err_start = err_cnt;
		send_instr(ooo_pkg::ALU_ADD, 6'(next_rand() % 64), 6'(next_rand() % 64), 1'b0, '0, d0);
		send_instr(ooo_pkg::ALU_SUB, d0, 6'(next_rand() % 64), 1'b0, '0, d1);
		send_instr(ooo_pkg::ALU_XOR, d1, '0, 1'b1, next_rand(), d2);
		send_instr(ooo_pkg::ALU_SRA, d2, '0, 1'b1, 32'd7, d3);
		end_dispatch();
		wait_drain(40);
		finish_test("chain", err_start);
	endtask

	// Two consumers of one producer wake together and complete on both ALUs at once
	task automatic run_pair_test();
		logic [ooo_pkg::PREG_W-1:0] dp;
		logic [ooo_pkg::PREG_W-1:0] da;
		logic [ooo_pkg::PREG_W-1:0] db;
		int err_start;
		int dual_start;
		err_start  = err_cnt;
		dual_start = dual_cnt;
		send_instr(ooo_pkg::ALU_ADD, 6'(next_rand() % 64), 6'(next_rand() % 64), 1'b0, '0, dp);
		send_instr(ooo_pkg::ALU_XOR, dp, 6'(next_rand() % 64), 1'b0, '0, da);
		send_instr(ooo_pkg::ALU_AND, dp, '0, 1'b1, next_rand(), db);
		end_dispatch();
		wait_drain(40);
		chk_cnt++;
		assert (dual_cnt > dual_start) else begin
			$display("The two independent instructions never completed in the same cycle");
			err_cnt++;
		end
		finish_test("pair", err_start);
	endtask

	task automatic run_burst_test();
		logic [ooo_pkg::PREG_W-1:0] recent [4];
		logic [ooo_pkg::PREG_W-1:0] s1;
		logic [ooo_pkg::PREG_W-1:0] s2;
		logic [ooo_pkg::PREG_W-1:0] d;
		logic [31:0] r;
		int err_start;
		int credit_start;
		int done_start;
		err_start    = err_cnt;
		credit_start = credit_total;
		done_start   = done_cnt;
		recent       = '{6'd1, 6'd2, 6'd3, 6'd4};
		for (int n = 0; n < 40; n++) begin
			r  = next_rand();
			s1 = r[0] ? recent[r[2:1]] : r[13:8];
			s2 = r[3] ? recent[r[5:4]] : r[19:14];
			send_instr(op_pick(int'(r[23:20])), s1, s2, r[24], next_rand(), d);
			recent[n % 4] = d;
			// Occasional idle cycle between dispatches
			if (r[31:29] == 3'd0) begin
				end_dispatch();
			end
		end
		end_dispatch();
		wait_drain(400);
		chk_cnt++;
		assert (done_cnt - done_start == 40 && credit_total - credit_start == 40
			&& credits == NUM_RS_ROWS) else begin
			$display("Burst ended with %0d completions, %0d credits returned, %0d credits held",
				done_cnt - done_start, credit_total - credit_start, credits);
			err_cnt++;
		end
		finish_test("burst", err_start);
	endtask

`default_nettype wire

/* bench/tb_dispatch_issue.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dispatch_issue;

	localparam int NUM_RS_ROWS = 16;
	localparam int NUM_ROB     = 1 << ooo_pkg::ROB_W;

	logic               clk_i;
	logic               arst_n_i;
	logic               dispatch_valid_i;
	ooo_pkg::dispatch_s dispatch_i;
	logic [1:0]         credit_cnt_o;
	logic               complete0_valid_o;
	logic               complete1_valid_o;
	ooo_pkg::complete_s complete0_o;
	ooo_pkg::complete_s complete1_o;

	// Register file as seen on the completion ports, and the values the rules predict
	logic [ooo_pkg::WORD_W-1:0]     regfile [ooo_pkg::NUM_P_REGS];
	logic [ooo_pkg::WORD_W-1:0]     exp_reg [ooo_pkg::NUM_P_REGS];
	logic [ooo_pkg::NUM_P_REGS-1:0] preg_busy;
	// Expected completion per ROB index in flight
	logic [NUM_ROB-1:0]             rob_busy;
	logic [ooo_pkg::WORD_W-1:0]     rob_val [NUM_ROB];
	logic [ooo_pkg::PREG_W-1:0]     rob_dest [NUM_ROB];
	logic [ooo_pkg::ROB_W-1:0]      rob_next;
	logic [31:0]                    lcg_state;
	int                             credits;
	int                             credit_total;
	int                             pending;
	int                             done_cnt;
	int                             dual_cnt;
	int                             err_cnt;
	int                             chk_cnt;
	int                             test_cnt;
	bit                             aborted;

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	dispatch_issue #(
		.NUM_RS_ROWS(NUM_RS_ROWS)
	) u_dut (
		.clk_i             (clk_i),
		.arst_n_i          (arst_n_i),
		.dispatch_valid_i  (dispatch_valid_i),
		.dispatch_i        (dispatch_i),
		.credit_cnt_o      (credit_cnt_o),
		.complete0_valid_o (complete0_valid_o),
		.complete1_valid_o (complete1_valid_o),
		.complete0_o       (complete0_o),
		.complete1_o       (complete1_o)
	);

	// Outputs are sampled mid-cycle, away from the driving edge
	always @(negedge clk_i) begin
		if (arst_n_i) begin
			credits      = credits + credit_cnt_o;
			credit_total = credit_total + credit_cnt_o;
			if (complete0_valid_o && complete1_valid_o) begin
				dual_cnt++;
			end
			if (complete0_valid_o) begin
				check_completion("complete0_o", complete0_o);
			end
			if (complete1_valid_o) begin
				check_completion("complete1_o", complete1_o);
			end
		end
	end

	initial begin
		arst_n_i         = 1'b0;
		dispatch_valid_i = 1'b0;
		dispatch_i       = '0;
		lcg_state        = 32'd93;
		credits          = NUM_RS_ROWS;
		credit_total     = 0;
		pending          = 0;
		done_cnt         = 0;
		dual_cnt         = 0;
		err_cnt          = 0;
		chk_cnt          = 0;
		test_cnt         = 0;
		aborted          = 1'b0;
		preg_busy        = '0;
		rob_busy         = '0;
		rob_next         = '0;
		for (int i = 0; i < ooo_pkg::NUM_P_REGS; i++) begin
			regfile[i] = 32'(i) * 32'h9e37_79b9 + 32'h0123_4567;
			exp_reg[i] = regfile[i];
		end
		repeat (2) @(posedge clk_i);
		arst_n_i <= 1'b1;
		run_reset_test();
		if (!aborted) run_op_test();
		if (!aborted) run_chain_test();
		if (!aborted) run_pair_test();
		if (!aborted) run_burst_test();
		$display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	`include "tb_tasks.svh"

endmodule

`default_nettype wire

/* flist.f */
+incdir+bench
hdl/ooo_pkg.sv
hdl/reg_scoreboard.sv
hdl/rs_station.sv
hdl/alu_unit.sv
hdl/dispatch_issue.sv
bench/tb_dispatch_issue.sv

/* hdl/alu_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
	input  wire                 clk_i,
	input  wire                 arst_n_i,
	input  wire                 issue_valid_i,
	input  ooo_pkg::issue_s     issue_i,
	output logic                complete_valid_o,
	output ooo_pkg::complete_s  complete_o
);

	localparam int SHAMT_W = $clog2(ooo_pkg::WORD_W);

	logic [ooo_pkg::WORD_W-1:0] result;

	always_comb begin
		case (issue_i.alu_op)
			ooo_pkg::ALU_AND: result = issue_i.op_a & issue_i.op_b;
			ooo_pkg::ALU_ADD: result = issue_i.op_a + issue_i.op_b;
			ooo_pkg::ALU_SUB: result = issue_i.op_a - issue_i.op_b;
			ooo_pkg::ALU_XOR: result = issue_i.op_a ^ issue_i.op_b;
			// Arithmetic shift keeps the sign of operand a
			ooo_pkg::ALU_SRA: result = $signed(issue_i.op_a) >>> issue_i.op_b[SHAMT_W-1:0];
			default:          result = '0;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			complete_valid_o <= 1'b0;
		end else begin
			complete_valid_o <= issue_valid_i;
		end
	end

	// Result register, only loaded on a real issue
	always_ff @(posedge clk_i) begin
		if (issue_valid_i) begin
			complete_o.dest    <= issue_i.dest;
			complete_o.value   <= result;
			complete_o.rob_idx <= issue_i.rob_idx;
		end
	end

	// Decode must only send the five supported opcodes
	a_legal_alu_op : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		issue_valid_i |-> issue_i.alu_op inside {
			ooo_pkg::ALU_AND,
			ooo_pkg::ALU_ADD,
			ooo_pkg::ALU_SUB,
			ooo_pkg::ALU_XOR,
			ooo_pkg::ALU_SRA
		}
	);

endmodule

`default_nettype wire

/* hdl/dispatch_issue.sv */
`timescale 1ns/100ps
`default_nettype none

module dispatch_issue #(
	parameter int NUM_RS_ROWS = 16
) (
	input  wire                 clk_i,
	input  wire                 arst_n_i,
	input  wire                 dispatch_valid_i,
	input  ooo_pkg::dispatch_s  dispatch_i,
	output logic [1:0]          credit_cnt_o,
	output logic                complete0_valid_o,
	output logic                complete1_valid_o,
	output ooo_pkg::complete_s  complete0_o,
	output ooo_pkg::complete_s  complete1_o
);

	logic [ooo_pkg::NUM_P_REGS-1:0] preg_ready;
	logic                           issue0_valid;
	logic                           issue1_valid;
	ooo_pkg::issue_s                issue0;
	ooo_pkg::issue_s                issue1;

	rs_station #(
		.NUM_RS_ROWS(NUM_RS_ROWS)
	) u_station (
		.clk_i             (clk_i),
		.arst_n_i          (arst_n_i),
		.dispatch_valid_i  (dispatch_valid_i),
		.dispatch_i        (dispatch_i),
		.preg_ready_i      (preg_ready),
		.complete0_valid_i (complete0_valid_o),
		.complete1_valid_i (complete1_valid_o),
		.complete0_i       (complete0_o),
		.complete1_i       (complete1_o),
		.issue0_valid_o    (issue0_valid),
		.issue1_valid_o    (issue1_valid),
		.issue0_o          (issue0),
		.issue1_o          (issue1),
		.credit_cnt_o      (credit_cnt_o)
	);

	// Dest goes busy at the same edge the row is written
	reg_scoreboard u_scoreboard (
		.clk_i             (clk_i),
		.arst_n_i          (arst_n_i),
		.alloc_valid_i     (dispatch_valid_i),
		.alloc_dest_i      (dispatch_i.dest),
		.complete0_valid_i (complete0_valid_o),
		.complete1_valid_i (complete1_valid_o),
		.complete0_i       (complete0_o),
		.complete1_i       (complete1_o),
		.preg_ready_o      (preg_ready)
	);

	alu_unit u_alu0 (
		.clk_i            (clk_i),
		.arst_n_i         (arst_n_i),
		.issue_valid_i    (issue0_valid),
		.issue_i          (issue0),
		.complete_valid_o (complete0_valid_o),
		.complete_o       (complete0_o)
	);

	alu_unit u_alu1 (
		.clk_i            (clk_i),
		.arst_n_i         (arst_n_i),
		.issue_valid_i    (issue1_valid),
		.issue_i          (issue1),
		.complete_valid_o (complete1_valid_o),
		.complete_o       (complete1_o)
	);

endmodule

`default_nettype wire

/* hdl/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

	// Datapath and tag widths
	localparam int WORD_W     = 32;
	localparam int NUM_P_REGS = 64;
	localparam int PREG_W     = 6;
	localparam int ROB_W      = 4;

	// ALU opcodes, encodings match the decode stage
	typedef enum logic [3:0] {
		ALU_AND = 4'b0000,
		ALU_ADD = 4'b0010,
		ALU_SUB = 4'b0110,
		ALU_XOR = 4'b1000,
		ALU_SRA = 4'b1001
	} alu_op_e;

	// One renamed instruction as it enters the station
	typedef struct packed {
		logic [PREG_W-1:0] dest;
		logic [PREG_W-1:0] src1;
		logic [WORD_W-1:0] src1_val;
		logic [PREG_W-1:0] src2;
		logic [WORD_W-1:0] src2_val;
		logic [WORD_W-1:0] imm;
		logic              use_imm;
		alu_op_e           alu_op;
		logic [ROB_W-1:0]  rob_idx;
	} dispatch_s;

	// Operation handed to an ALU, operand b already muxed
	typedef struct packed {
		logic [PREG_W-1:0] dest;
		logic [WORD_W-1:0] op_a;
		logic [WORD_W-1:0] op_b;
		alu_op_e           alu_op;
		logic [ROB_W-1:0]  rob_idx;
	} issue_s;

	// Result broadcast to the ROB, station and scoreboard
	typedef struct packed {
		logic [PREG_W-1:0] dest;
		logic [WORD_W-1:0] value;
		logic [ROB_W-1:0]  rob_idx;
	} complete_s;

endpackage

`default_nettype wire

/* hdl/reg_scoreboard.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_scoreboard (
	input  wire                                clk_i,
	input  wire                                arst_n_i,
	input  wire                                alloc_valid_i,
	input  wire  [ooo_pkg::PREG_W-1:0]         alloc_dest_i,
	input  wire                                complete0_valid_i,
	input  wire                                complete1_valid_i,
	input  ooo_pkg::complete_s                 complete0_i,
	input  ooo_pkg::complete_s                 complete1_i,
	output logic [ooo_pkg::NUM_P_REGS-1:0]     preg_ready_o
);

	logic [ooo_pkg::NUM_P_REGS-1:0] ready_q;

	// Completions set ready, a new allocation clears it.
	// Register 0 is never allocated so its bit stays set from reset
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ready_q <= '1;
		end else begin
			if (complete0_valid_i) begin
				ready_q[complete0_i.dest] <= 1'b1;
			end
			if (complete1_valid_i) begin
				ready_q[complete1_i.dest] <= 1'b1;
			end
			if (alloc_valid_i && alloc_dest_i != '0) begin
				ready_q[alloc_dest_i] <= 1'b0;
			end
		end
	end

	assign preg_ready_o = ready_q;

	// Rename must not hand out a tag that still has a result in flight
	a_alloc_free_tag : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		(alloc_valid_i && alloc_dest_i != '0) |-> ready_q[alloc_dest_i]
	);

endmodule

`default_nettype wire

/* hdl/rs_station.sv */
`timescale 1ns/100ps
`default_nettype none

module rs_station #(
	parameter int NUM_RS_ROWS = 16
) (
	input  wire                             clk_i,
	input  wire                             arst_n_i,
	input  wire                             dispatch_valid_i,
	input  ooo_pkg::dispatch_s              dispatch_i,
	input  wire  [ooo_pkg::NUM_P_REGS-1:0]  preg_ready_i,
	input  wire                             complete0_valid_i,
	input  wire                             complete1_valid_i,
	input  ooo_pkg::complete_s              complete0_i,
	input  ooo_pkg::complete_s              complete1_i,
	output logic                            issue0_valid_o,
	output logic                            issue1_valid_o,
	output ooo_pkg::issue_s                 issue0_o,
	output ooo_pkg::issue_s                 issue1_o,
	output logic [1:0]                      credit_cnt_o
);

	localparam int IDX_W = $clog2(NUM_RS_ROWS);

	typedef struct packed {
		logic                       rdy;
		logic [ooo_pkg::WORD_W-1:0] val;
	} src_s;

	// Control state per row
	logic [NUM_RS_ROWS-1:0] row_used;
	logic [NUM_RS_ROWS-1:0] src1_rdy;
	logic [NUM_RS_ROWS-1:0] src2_rdy;
	// Payload per row
	ooo_pkg::dispatch_s     row_q [NUM_RS_ROWS];

	src_s                   wake1 [NUM_RS_ROWS];
	src_s                   wake2 [NUM_RS_ROWS];
	src_s                   disp1;
	src_s                   disp2;
	logic                   free_vld;
	logic [IDX_W-1:0]       free_idx;
	logic                   sel0_vld;
	logic                   sel1_vld;
	logic [IDX_W-1:0]       sel0_idx;
	logic [IDX_W-1:0]       sel1_idx;

	// A waiting source picks up a completion that names its tag
	function automatic src_s resolve_src(
		input logic                        rdy,
		input logic [ooo_pkg::WORD_W-1:0]  val,
		input logic [ooo_pkg::PREG_W-1:0]  tag,
		input logic                        c0_vld,
		input ooo_pkg::complete_s          c0,
		input logic                        c1_vld,
		input ooo_pkg::complete_s          c1
	);
		src_s res;
		res.rdy = rdy;
		res.val = val;
		if (!rdy && c0_vld && c0.dest == tag) begin
			res.rdy = 1'b1;
			res.val = c0.value;
		end else if (!rdy && c1_vld && c1.dest == tag) begin
			res.rdy = 1'b1;
			res.val = c1.value;
		end
		return res;
	endfunction

	function automatic ooo_pkg::issue_s make_issue(input ooo_pkg::dispatch_s row);
		ooo_pkg::issue_s iss;
		iss.dest    = row.dest;
		iss.op_a    = row.src1_val;
		iss.op_b    = row.use_imm ? row.imm : row.src2_val;
		iss.alu_op  = row.alu_op;
		iss.rob_idx = row.rob_idx;
		return iss;
	endfunction

	// Same-cycle bypass for the incoming instruction
	assign disp1 = resolve_src(preg_ready_i[dispatch_i.src1], dispatch_i.src1_val, dispatch_i.src1,
		complete0_valid_i, complete0_i, complete1_valid_i, complete1_i);
	assign disp2 = resolve_src(preg_ready_i[dispatch_i.src2], dispatch_i.src2_val, dispatch_i.src2,
		complete0_valid_i, complete0_i, complete1_valid_i, complete1_i);

	always_comb begin
		for (int i = 0; i < NUM_RS_ROWS; i++) begin
			wake1[i] = resolve_src(src1_rdy[i], row_q[i].src1_val, row_q[i].src1,
				complete0_valid_i, complete0_i, complete1_valid_i, complete1_i);
			wake2[i] = resolve_src(src2_rdy[i], row_q[i].src2_val, row_q[i].src2,
				complete0_valid_i, complete0_i, complete1_valid_i, complete1_i);
		end
	end

	// Lowest free row takes the dispatch, lowest two ready rows issue
	always_comb begin
		free_vld = 1'b0;
		free_idx = '0;
		sel0_vld = 1'b0;
		sel1_vld = 1'b0;
		sel0_idx = '0;
		sel1_idx = '0;
		for (int i = 0; i < NUM_RS_ROWS; i++) begin
			if (!row_used[i] && !free_vld) begin
				free_vld = 1'b1;
				free_idx = IDX_W'(i);
			end
			if (row_used[i] && src1_rdy[i] && (src2_rdy[i] || row_q[i].use_imm)) begin
				if (!sel0_vld) begin
					sel0_vld = 1'b1;
					sel0_idx = IDX_W'(i);
				end else if (!sel1_vld) begin
					sel1_vld = 1'b1;
					sel1_idx = IDX_W'(i);
				end
			end
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			row_used       <= '0;
			src1_rdy       <= '0;
			src2_rdy       <= '0;
			issue0_valid_o <= 1'b0;
			issue1_valid_o <= 1'b0;
		end else begin
			for (int i = 0; i < NUM_RS_ROWS; i++) begin
				src1_rdy[i] <= wake1[i].rdy;
				src2_rdy[i] <= wake2[i].rdy;
			end
			if (sel0_vld) begin
				row_used[sel0_idx] <= 1'b0;
			end
			if (sel1_vld) begin
				row_used[sel1_idx] <= 1'b0;
			end
			if (dispatch_valid_i) begin
				row_used[free_idx] <= 1'b1;
				src1_rdy[free_idx] <= disp1.rdy;
				src2_rdy[free_idx] <= disp2.rdy;
			end
			issue0_valid_o <= sel0_vld;
			issue1_valid_o <= sel1_vld;
		end
	end

	always_ff @(posedge clk_i) begin
		for (int i = 0; i < NUM_RS_ROWS; i++) begin
			row_q[i].src1_val <= wake1[i].val;
			row_q[i].src2_val <= wake2[i].val;
		end
		if (dispatch_valid_i) begin
			row_q[free_idx]          <= dispatch_i;
			row_q[free_idx].src1_val <= disp1.val;
			row_q[free_idx].src2_val <= disp2.val;
		end
		if (sel0_vld) begin
			issue0_o <= make_issue(row_q[sel0_idx]);
		end
		if (sel1_vld) begin
			issue1_o <= make_issue(row_q[sel1_idx]);
		end
	end

	// Rows freed by the issue that just left
	assign credit_cnt_o = {1'b0, issue0_valid_o} + {1'b0, issue1_valid_o};

	// Sender has overrun its credits
	a_no_dispatch_when_full : assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		dispatch_valid_i |-> free_vld
	);

endmodule

`default_nettype wire
